// File: rtl/dsp_mailbox.sv
/* CPU to DSP command path, the address byte write raises the DSP irq
   the DSP reads address then data with two pids_n strobes */
`timescale 1ns/1ps
`default_nettype none

module dsp_mailbox (
    input  wire        clk48,
    input  wire        rst,
    input  wire        mbox_wr,
    input  wire [ 2:0] bus_addr_lo,
    input  wire [ 7:0] bus_din,
    input  wire        dsp_pids_n,
    input  wire        dsp_iack,
    output logic [ 7:0] mbox_dout,
    output logic [ 3:0] bank,
    output logic        dsp_rst,
    output logic        dsp_irq,
    output logic [15:0] dsp_pbus_in
);

    logic [23:0] cmd;          // {addr, data_hi, data_lo}
    logic [ 1:0] sel;
    logic        last_pids_n;

    wire cmd_go   = mbox_wr && bus_addr_lo == qsnd_pkg::REG_CMD_ADDR;
    wire pids_end = dsp_pids_n && !last_pids_n;

    always_ff @(posedge clk48) begin
        if (mbox_wr) begin
            case (bus_addr_lo)
                qsnd_pkg::REG_DATA_HI:  cmd[15: 8] <= bus_din;
                qsnd_pkg::REG_DATA_LO:  cmd[ 7: 0] <= bus_din;
                qsnd_pkg::REG_CMD_ADDR: cmd[23:16] <= bus_din;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank        <= 4'd0;
            dsp_rst     <= 1'b1;
            dsp_irq     <= 1'b0;
            sel         <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (mbox_wr && bus_addr_lo == qsnd_pkg::REG_BANK) begin
                bank    <= bus_din[3:0];
                dsp_rst <= ~bus_din[7];   // bit 7 set runs the DSP
            end
            if (cmd_go) begin
                dsp_irq <= 1'b1;
                sel     <= 2'b11;
            end else if (pids_end) begin
                dsp_irq <= 1'b0;
                sel     <= sel >> 1;      // address first, then data
            end
        end
    end

    assign dsp_pbus_in = sel[1] ? {8'd0, cmd[23:16]} : cmd[15:0];
    assign mbox_dout   = {~(dsp_irq | dsp_iack), 3'b111, bank}; // busy when low

endmodule

`default_nettype wire

// File: rtl/dsp_out_latch.sv
/* DSP side output registers, strobes are sampled on clk48 so each
   strobe level must last at least one clk48 cycle */
`timescale 1ns/1ps
`default_nettype none

module dsp_out_latch (
    input  wire        clk48,
    input  wire        rst,
    input  wire        dsp_sadd,
    input  wire        dsp_psel,
    input  wire [15:0] dsp_ser_out,
    input  wire        dsp_pods_n,
    input  wire [15:0] dsp_pbus_out,
    input  wire [15:0] dsp_ab,
    input  wire        dsp_cen_cko,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample,
    output logic [qsnd_pkg::QADDR_W-1:0] qsnd_addr
);

    logic [15:0] pend_l, pend_r;
    logic        last_sadd, last_psel, last_pods_n;

    wire sadd_fall = !dsp_sadd && last_sadd;
    wire psel_rise = dsp_psel && !last_psel;
    wire pods_rise = dsp_pods_n && !last_pods_n;

    // serial word taken in parallel, psel tells the channel
    always_ff @(posedge clk48) begin
        if (sadd_fall) begin
            if (dsp_psel) pend_r <= dsp_ser_out << qsnd_pkg::AUDIO_SHIFT;
            else          pend_l <= dsp_ser_out << qsnd_pkg::AUDIO_SHIFT;
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd   <= 1'b0;
            last_psel   <= 1'b0;
            last_pods_n <= 1'b1;
            left        <= 16'sd0;
            right       <= 16'sd0;
            sample      <= 1'b0;
            qsnd_addr   <= '0;
        end else begin
            last_sadd   <= dsp_sadd;
            last_psel   <= dsp_psel;
            last_pods_n <= dsp_pods_n;
            sample      <= psel_rise;     // one cycle strobe per pair
            if (psel_rise) begin
                left  <= pend_l;
                right <= pend_r;
            end
            if (pods_rise) qsnd_addr[15:0] <= dsp_pbus_out;
            if (dsp_cen_cko && dsp_ab[15]) begin
                // upper bits come off the DSP address bus
                qsnd_addr[qsnd_pkg::QADDR_W-1:16] <= dsp_ab[qsnd_pkg::QADDR_W-17:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/qsnd_pkg.sv
/* address map, timing and widths for the QSound sound board glue
   page codes are the upper nibble of the 16-bit sound CPU address */
`default_nettype none

package qsnd_pkg;

    // memory widths
    localparam int RAM_AW  = 13;        // 8 kB shared work RAM
    localparam int ROM_AW  = 19;        // 512 kB program ROM
    localparam int QADDR_W = 23;        // sample ROM, up to 8 MB

    // banked window 0x8000-0xBFFF lands above the fixed 32 kB
    localparam logic [ROM_AW-1:0] BANK_BASE = 19'h0_8000;

    // sound CPU interrupt rate in cen8 ticks
    localparam int IRQ_PERIOD = 32000;

    // upper address nibble
    localparam logic [3:0] PAGE_RAM_LO     = 4'hc;
    localparam logic [3:0] PAGE_RAM_HI     = 4'hf;
    localparam logic [3:0] PAGE_QSND       = 4'hd;
    localparam logic [3:0] PAGE_FETCH_WAIT = 4'h4; // first page with a fetch wait

    // mailbox offsets inside the 0xD page
    localparam logic [2:0] REG_DATA_HI  = 3'd0;
    localparam logic [2:0] REG_DATA_LO  = 3'd1;
    localparam logic [2:0] REG_CMD_ADDR = 3'd2; // writing this one kicks the DSP
    localparam logic [2:0] REG_BANK     = 3'd3;
    localparam logic [2:0] REG_STATUS   = 3'd7;

    // DSP serial output is scaled up before leaving the board
    localparam int AUDIO_SHIFT = 3;

endpackage

`default_nettype wire

// File: rtl/qsnd_sound.sv
/* sound CPU glue top, CPU and DSP cores are outside, single clk48 domain
   cen8 must be a one cycle enable, the sound CPU runs on cpu_cen */
`timescale 1ns/1ps
`default_nettype none

module qsnd_sound (
    input  wire         clk48,
    input  wire         rst,
    input  wire         cen8,
    // sound CPU bus
    input  wire  [15:0] cpu_addr,
    input  wire  [ 7:0] cpu_dout,
    input  wire         cpu_mreq_n,
    input  wire         cpu_rd_n,
    input  wire         cpu_wr_n,
    input  wire         cpu_m1_n,
    input  wire         cpu_iorq_n,
    input  wire         cpu_busak_n,
    output logic [ 7:0] cpu_din,
    output logic        cpu_cen,
    output logic        cpu_int_n,
    output logic        cpu_busrq_n,
    // program ROM
    output logic [qsnd_pkg::ROM_AW-1:0] rom_addr,
    output logic        rom_cs,
    input  wire  [ 7:0] rom_data,
    input  wire         rom_ok,
    // main CPU
    input  wire  [23:1] main_addr,
    input  wire  [ 7:0] main_dout,
    input  wire         main_ldswn,
    input  wire         main_buse_n,
    output logic [ 7:0] main_din,
    output logic        main_busakn,
    // DSP parallel and serial side
    input  wire         dsp_pids_n,
    input  wire         dsp_iack,
    input  wire         dsp_pods_n,
    input  wire  [15:0] dsp_pbus_out,
    input  wire  [15:0] dsp_ab,
    input  wire         dsp_cen_cko,
    input  wire         dsp_sadd,
    input  wire         dsp_psel,
    input  wire  [15:0] dsp_ser_out,
    output logic [15:0] dsp_pbus_in,
    output logic        dsp_irq,
    output logic        dsp_rst,
    // audio and sample ROM address
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic        sample,
    output logic [qsnd_pkg::QADDR_W-1:0] qsnd_addr
);

    logic        main_busn;
    logic [15:0] bus_addr;
    logic [ 7:0] bus_din, ram_q, mbox_dout;
    logic        bus_wr_n, ram_we, mbox_wr;
    logic [ 3:0] bank;

    snd_bus_lock u_buslock (
        .clk48       (clk48),
        .rst         (rst),
        .cen8        (cen8),
        .main_buse_n (main_buse_n),
        .cpu_busak_n (cpu_busak_n),
        .cpu_busrq_n (cpu_busrq_n),
        .main_busn   (main_busn)
    );

    snd_tick_irq u_irq (
        .clk48      (clk48),
        .rst        (rst),
        .cen8       (cen8),
        .cpu_m1_n   (cpu_m1_n),
        .cpu_iorq_n (cpu_iorq_n),
        .cpu_int_n  (cpu_int_n)
    );

    snd_addr_decode u_decode (
        .clk48       (clk48),
        .rst         (rst),
        .cen8        (cen8),
        .main_busn   (main_busn),
        .cpu_addr    (cpu_addr),
        .cpu_dout    (cpu_dout),
        .cpu_mreq_n  (cpu_mreq_n),
        .cpu_rd_n    (cpu_rd_n),
        .cpu_wr_n    (cpu_wr_n),
        .cpu_m1_n    (cpu_m1_n),
        .main_addr   (main_addr[16:1]), // 128 kB window seen by the 68000
        .main_dout   (main_dout),
        .main_ldswn  (main_ldswn),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .ram_q       (ram_q),
        .mbox_dout   (mbox_dout),
        .bank        (bank),
        .bus_addr    (bus_addr),
        .bus_din     (bus_din),
        .bus_wr_n    (bus_wr_n),
        .ram_we      (ram_we),
        .mbox_wr     (mbox_wr),
        .mbox_rd     (),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .cpu_din     (cpu_din),
        .cpu_cen     (cpu_cen),
        .main_din    (main_din),
        .main_busakn (main_busakn)
    );

    snd_ram u_ram (
        .clk48 (clk48),
        .addr  (bus_addr[qsnd_pkg::RAM_AW-1:0]),
        .din   (bus_din),
        .we    (ram_we),
        .q     (ram_q)
    );

    dsp_mailbox u_mbox (
        .clk48       (clk48),
        .rst         (rst),
        .mbox_wr     (mbox_wr & ~bus_wr_n),
        .bus_addr_lo (bus_addr[2:0]),
        .bus_din     (bus_din),
        .dsp_pids_n  (dsp_pids_n),
        .dsp_iack    (dsp_iack),
        .mbox_dout   (mbox_dout),
        .bank        (bank),
        .dsp_rst     (dsp_rst),
        .dsp_irq     (dsp_irq),
        .dsp_pbus_in (dsp_pbus_in)
    );

    dsp_out_latch u_outlatch (
        .clk48        (clk48),
        .rst          (rst),
        .dsp_sadd     (dsp_sadd),
        .dsp_psel     (dsp_psel),
        .dsp_ser_out  (dsp_ser_out),
        .dsp_pods_n   (dsp_pods_n),
        .dsp_pbus_out (dsp_pbus_out),
        .dsp_ab       (dsp_ab),
        .dsp_cen_cko  (dsp_cen_cko),
        .left         (left),
        .right        (right),
        .sample       (sample),
        .qsnd_addr    (qsnd_addr)
    );

endmodule

`default_nettype wire

// File: rtl/snd_addr_decode.sv
/* chip selects are registered one clk48 after mreq_n, so accesses need
   at least three clk48 cycles; ROM reads return raw data, no decryption */
`timescale 1ns/1ps
`default_nettype none

module snd_addr_decode (
    input  wire        clk48,
    input  wire        rst,
    input  wire        cen8,
    input  wire        main_busn,
    input  wire [15:0] cpu_addr,
    input  wire [ 7:0] cpu_dout,
    input  wire        cpu_mreq_n,
    input  wire        cpu_rd_n,
    input  wire        cpu_wr_n,
    input  wire        cpu_m1_n,
    input  wire [16:1] main_addr,
    input  wire [ 7:0] main_dout,
    input  wire        main_ldswn,
    input  wire [ 7:0] rom_data,
    input  wire        rom_ok,
    input  wire [ 7:0] ram_q,
    input  wire [ 7:0] mbox_dout,
    input  wire [ 3:0] bank,
    output logic [15:0] bus_addr,
    output logic [ 7:0] bus_din,
    output logic        bus_wr_n,
    output logic        ram_we,
    output logic        mbox_wr,
    output logic        mbox_rd,
    output logic [qsnd_pkg::ROM_AW-1:0] rom_addr,
    output logic        rom_cs,
    output logic [ 7:0] cpu_din,
    output logic        cpu_cen,
    output logic [ 7:0] main_din,
    output logic        main_busakn
);

    logic       bus_mreq_n, bus_rd_n;
    logic       ram_cs;
    logic       rom_done;          // rom_ok already seen for this access
    logic       busn_dly;
    logic       fetch_taken, fetch_skip;
    logic [3:0] page;
    logic [qsnd_pkg::ROM_AW-1:0] fixed_addr, bank_addr;

    // bus owner mux, main CPU has mreq asserted for the whole grant
    assign bus_addr   = main_busn ? cpu_addr   : main_addr;
    assign bus_din    = main_busn ? cpu_dout   : main_dout;
    assign bus_wr_n   = main_busn ? cpu_wr_n   : main_ldswn;
    assign bus_rd_n   = main_busn ? cpu_rd_n   : ~main_ldswn;
    assign bus_mreq_n = main_busn & cpu_mreq_n;
    assign page       = bus_addr[15:12];

    assign fixed_addr = {{(qsnd_pkg::ROM_AW-15){1'b0}}, bus_addr[14:0]};
    assign bank_addr  = {{(qsnd_pkg::ROM_AW-18){1'b0}}, bank, bus_addr[13:0]}
                        + qsnd_pkg::BANK_BASE;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            mbox_wr  <= 1'b0;
            mbox_rd  <= 1'b0;
            rom_done <= 1'b0;
        end else begin
            rom_cs  <= !bus_mreq_n && page < qsnd_pkg::PAGE_RAM_LO;
            ram_cs  <= !bus_mreq_n && (page == qsnd_pkg::PAGE_RAM_LO ||
                                       page == qsnd_pkg::PAGE_RAM_HI);
            mbox_wr <= !bus_mreq_n && !bus_wr_n && page == qsnd_pkg::PAGE_QSND &&
                       bus_addr[2:0] <= qsnd_pkg::REG_BANK;
            mbox_rd <= !bus_mreq_n && !bus_rd_n && page == qsnd_pkg::PAGE_QSND &&
                       bus_addr[2:0] == qsnd_pkg::REG_STATUS;
            rom_done <= rom_cs && (rom_done || rom_ok);
        end
    end

    always_ff @(posedge clk48) begin
        if (!bus_mreq_n) begin
            rom_addr <= bus_addr[15] ? bank_addr : fixed_addr;
        end
        main_din <= cpu_din;
    end

    assign ram_we = ram_cs & ~bus_wr_n;

    always_comb begin
        if (rom_cs)       cpu_din = rom_data;
        else if (ram_cs)  cpu_din = ram_q;
        else if (mbox_rd) cpu_din = mbox_dout;
        else              cpu_din = 8'hff;  // open bus
    end

    // one extra wait per opcode fetch from page 4 upwards
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            fetch_taken <= 1'b0;
            fetch_skip  <= 1'b0;
            busn_dly    <= 1'b1;
        end else begin
            busn_dly <= main_busn;
            if (cen8 && fetch_skip) fetch_skip <= 1'b0; // tick swallowed
            if (cpu_m1_n) begin
                fetch_taken <= 1'b0;
            end else if (cpu_addr[15:12] >= qsnd_pkg::PAGE_FETCH_WAIT && !fetch_taken) begin
                fetch_taken <= 1'b1;
                fetch_skip  <= 1'b1;
            end
        end
    end

    assign cpu_cen     = cen8 & ~fetch_skip;
    assign main_busakn = busn_dly | (rom_cs & ~(rom_ok | rom_done));

endmodule

`default_nettype wire

// File: rtl/snd_bus_lock.sv
/* main CPU bus request path, grant only after two cen8 ticks of busak_n
   releasing buse_n drops the grant without waiting for cen8 */
`timescale 1ns/1ps
`default_nettype none

module snd_bus_lock (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  main_buse_n,
    input  wire  cpu_busak_n,
    output logic cpu_busrq_n,
    output logic main_busn     // low while the main CPU owns the bus
);

    logic [1:0] latch;

    assign cpu_busrq_n = main_buse_n;  // request goes straight through
    assign main_busn   = latch[1];

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            latch <= 2'b11;
        end else begin
            if (main_buse_n) begin
                latch <= 2'b11;        // released
            end else if (cen8) begin
                // acknowledge shifts in while the request is held
                latch <= {latch[0], cpu_busak_n};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/snd_ram.sv
/* single port work RAM, write and read on the same clk48 edge
   read data is registered, one cycle after the address */
`timescale 1ns/1ps
`default_nettype none

module snd_ram (
    input  wire                        clk48,
    input  wire [qsnd_pkg::RAM_AW-1:0] addr,
    input  wire [7:0]                  din,
    input  wire                        we,
    output logic [7:0]                 q
);

    logic [7:0] mem [0:(1 << qsnd_pkg::RAM_AW) - 1];

    always_ff @(posedge clk48) begin
        if (we) begin
            mem[addr] <= din;
        end
        q <= mem[addr];    // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: rtl/snd_tick_irq.sv
/* free running interrupt timer on cen8, period fixed by the package
   int_n stays low until an M1+IORQ acknowledge is seen on a cen8 tick */
`timescale 1ns/1ps
`default_nettype none

module snd_tick_irq (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  cpu_m1_n,
    input  wire  cpu_iorq_n,
    output logic cpu_int_n
);

    int  cnt;
    wire wrap = (cnt == qsnd_pkg::IRQ_PERIOD - 1);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt       <= 0;
            cpu_int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? 0 : cnt + 1;
            if (!cpu_m1_n && !cpu_iorq_n) begin
                cpu_int_n <= 1'b1;     // acknowledge cycle
            end else if (wrap) begin
                cpu_int_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile the QSound glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module qsnd_tb -f sources.f

# the simulation output decides pass or fail
out=$(./obj_dir/Vqsnd_tb)
echo "$out"
echo "$out" | grep -q "^Regression passed$"

// File: sources.f
rtl/qsnd_pkg.sv
rtl/snd_bus_lock.sv
rtl/snd_tick_irq.sv
rtl/snd_addr_decode.sv
rtl/snd_ram.sv
rtl/dsp_mailbox.sv
rtl/dsp_out_latch.sv
rtl/qsnd_sound.sv
verif/qsnd_tb.sv

// File: verif/qsnd_tb.sv
/* directed testbench, it plays the sound CPU, the main CPU, the program ROM and the DSP
   every sound CPU access holds its strobes three clk48 cycles, longer while rom_ok is due */
`timescale 1ns/1ps
`default_nettype none

module qsnd_tb;

    logic        clk48, rst, cen8;
    logic [15:0] cpu_addr;
    logic [ 7:0] cpu_dout;
    logic        cpu_mreq_n, cpu_rd_n, cpu_wr_n, cpu_m1_n, cpu_iorq_n, cpu_busak_n;
    wire  [ 7:0] cpu_din;
    wire         cpu_cen, cpu_int_n, cpu_busrq_n;
    wire  [qsnd_pkg::ROM_AW-1:0] rom_addr;
    wire         rom_cs;
    logic [ 7:0] rom_data;
    logic        rom_ok;
    logic [23:1] main_addr;
    logic [ 7:0] main_dout;
    logic        main_ldswn, main_buse_n;
    wire  [ 7:0] main_din;
    wire         main_busakn;
    logic        dsp_pids_n, dsp_iack, dsp_pods_n, dsp_cen_cko, dsp_sadd, dsp_psel;
    logic [15:0] dsp_pbus_out, dsp_ab, dsp_ser_out;
    wire  [15:0] dsp_pbus_in;
    wire         dsp_irq, dsp_rst;
    wire signed [15:0] left, right;
    wire         sample;
    wire  [qsnd_pkg::QADDR_W-1:0] qsnd_addr;

    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          lost_ticks = 0;    // cen8 ticks held back from the CPU
    int          sample_cnt = 0;
    int          ticks = 0;         // cen8 ticks since reset release
    int          fall_tick = -1;
    logic [31:0] seed = 32'h88df;
    logic [ 3:0] cur_bank = 4'd0;

    qsnd_sound dut0 (.*);

    initial begin
        clk48 = 1'b0;
        forever #4 clk48 = ~clk48;
    end

    // one tick in six clk48 cycles
    initial begin : cen_gen
        int phase;
        phase = 0;
        cen8  = 1'b0;
        forever begin
            @(posedge clk48);
            #1;
            cen8  = (phase == 5);
            phase = (phase == 5) ? 0 : phase + 1;
        end
    end

    always @(negedge clk48) begin
        if (cen8 && !cpu_cen) lost_ticks <= lost_ticks + 1;
        if (sample) sample_cnt <= sample_cnt + 1;
        if (!rst && cen8) ticks <= ticks + 1;
        if (!cpu_int_n && fall_tick < 0) fall_tick <= ticks;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 6 * qsnd_pkg::IRQ_PERIOD + 68000) begin  // irq wait dominates
            @(posedge clk48);
            cycles = cycles + 1;
        end
        $display("timeout after %0d clock cycles, the tests did not finish", cycles);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [7:0] lcg_byte();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    // ROM contents as a function of the byte address
    function automatic logic [7:0] rom_byte(input logic [qsnd_pkg::ROM_AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {a[18:16], 5'h15};
    endfunction

    function automatic logic [qsnd_pkg::ROM_AW-1:0] rom_target(input logic [15:0] a,
                                                              input logic [3:0]  b);
        if (!a[15]) return 19'(a);
        return qsnd_pkg::BANK_BASE + 19'(b) * 19'h4000 + 19'(a[13:0]);
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("error at time %0t: %s, got %0h expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests = tests + 1;
        if (errors > err_start) begin
            failed_tests = failed_tests + 1;
            $display("%s: %0d errors", name, errors - err_start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // answers every ROM select two cycles late
    task automatic rom_model();
        int wait_cnt;
        wait_cnt = 0;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(posedge clk48);
            #1;
            if (rom_cs) begin
                wait_cnt = wait_cnt + 1;
                rom_ok   = (wait_cnt == 2);
                if (wait_cnt == 2) rom_data = rom_byte(rom_addr);
            end else begin
                wait_cnt = 0;
                rom_ok   = 1'b0;
            end
        end
    endtask

    initial rom_model();

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk48);
        #1;
        cpu_addr   = addr;
        cpu_dout   = data;
        cpu_mreq_n = 1'b0;
        cpu_wr_n   = 1'b0;
        repeat (3) @(posedge clk48);
        #1;
        cpu_mreq_n = 1'b1;
        cpu_wr_n   = 1'b1;
    endtask

    task automatic cpu_read(input logic [15:0] addr, input logic fetch,
                            output logic [7:0] data);
        int n;
        @(posedge clk48);
        #1;
        cpu_addr   = addr;
        cpu_mreq_n = 1'b0;
        cpu_rd_n   = 1'b0;
        cpu_m1_n   = ~fetch;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
        n = 0;
        while (rom_cs && !rom_ok && n < 16) begin
            @(negedge clk48);
            n = n + 1;
        end
        if (rom_cs && !rom_ok) begin
            errors = errors + 1;
            $display("ROM read at %h never got rom_ok", addr);
        end
        data = cpu_din;
        @(posedge clk48);
        #1;
        cpu_mreq_n = 1'b1;
        cpu_rd_n   = 1'b1;
        cpu_m1_n   = 1'b1;
    endtask

    // main CPU takes the bus, writes one byte and hands the bus back
    task automatic main_write(input logic [15:0] addr, input logic [7:0] data);
        int n;
        @(posedge clk48);
        #1;
        main_addr   = {7'd0, addr};
        main_dout   = data;
        main_ldswn  = 1'b1;
        main_buse_n = 1'b0;
        @(negedge clk48);
        check(32'(cpu_busrq_n), 32'd0, "bus request not passed to the sound CPU");
        @(posedge clk48);
        #1;
        cpu_busak_n = 1'b0;            // sound CPU lets go of the bus
        n = 0;
        while (main_busakn && n < 40) begin
            @(negedge clk48);
            n = n + 1;
        end
        if (main_busakn) begin
            errors = errors + 1;
            $display("main CPU never got the bus, main_busakn stayed high");
        end else begin
            @(posedge clk48);
            #1;
            main_ldswn = 1'b0;
            repeat (2) @(posedge clk48);
            #1;
            main_ldswn = 1'b1;
            repeat (2) @(posedge clk48);  // main side reads the byte back
            @(negedge clk48);
            check(32'(main_din), 32'(data), "main CPU read back");
        end
        @(posedge clk48);
        #1;
        main_buse_n = 1'b1;
        cpu_busak_n = 1'b1;
    endtask

    task automatic sadd_strobe(input logic [15:0] value, input logic psel);
        @(posedge clk48);
        #1;
        dsp_ser_out = value;
        dsp_psel    = psel;
        dsp_sadd    = 1'b1;
        repeat (2) @(posedge clk48);
        #1;
        dsp_sadd = 1'b0;               // falling edge takes the word
        repeat (2) @(posedge clk48);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        @(negedge clk48);
        check(32'(cpu_int_n), 32'd1, "cpu_int_n after reset");
        check(32'(cpu_busrq_n), 32'd1, "cpu_busrq_n after reset");
        check(32'(main_busakn), 32'd1, "main_busakn after reset");
        check(32'(dsp_rst), 32'd1, "dsp_rst after reset");
        check(32'(dsp_irq), 32'd0, "dsp_irq after reset");
        check(32'(rom_cs), 32'd0, "rom_cs after reset");
        check(32'(sample), 32'd0, "sample after reset");
        check(32'($unsigned(left)), 32'd0, "left after reset");
        check(32'($unsigned(right)), 32'd0, "right after reset");
        check(32'(qsnd_addr), 32'd0, "qsnd_addr after reset");
        finish_test("reset values", e0);
    endtask

    task automatic rom_bank_and_wait();
        int         e0, lost0;
        logic [7:0] d;
        e0 = errors;
        cur_bank = 4'd5;
        cpu_write(16'hd003, {4'h0, cur_bank});
        cpu_read(16'h1234, 1'b0, d);
        check(32'(rom_addr), 32'(rom_target(16'h1234, cur_bank)), "rom_addr for 0x1234");
        check(32'(d), 32'(rom_byte(rom_target(16'h1234, cur_bank))), "ROM data at 0x1234");
        cpu_read(16'h9234, 1'b0, d);
        check(32'(rom_addr), 32'(rom_target(16'h9234, cur_bank)), "banked rom_addr");
        check(32'(d), 32'(rom_byte(rom_target(16'h9234, cur_bank))), "banked ROM data");
        lost0 = lost_ticks;
        cpu_read(16'h4000, 1'b1, d);
        repeat (8) @(posedge clk48);   // a cen8 tick falls in this window
        @(negedge clk48);
        check(32'(lost_ticks - lost0), 32'd1, "ticks lost on a fetch at 0x4000");
        lost0 = lost_ticks;
        cpu_read(16'h0100, 1'b1, d);
        repeat (8) @(posedge clk48);
        @(negedge clk48);
        check(32'(lost_ticks - lost0), 32'd0, "ticks lost on a fetch at 0x0100");
        finish_test("rom banking and fetch wait", e0);
    endtask

    task automatic ram_sharing();
        int         e0;
        logic [7:0] d1, d2, d3, d;
        e0 = errors;
        d1 = lcg_byte();
        d2 = lcg_byte();
        d3 = lcg_byte();
        cpu_write(16'hc010, d1);
        cpu_write(16'hf020, d2);
        cpu_read(16'hc010, 1'b0, d);
        check(32'(d), 32'(d1), "RAM read at 0xc010");
        cpu_read(16'hf020, 1'b0, d);
        check(32'(d), 32'(d2), "RAM read at 0xf020");
        main_write(16'hc030, d3);
        cpu_read(16'hc030, 1'b0, d);
        check(32'(d), 32'(d3), "sound CPU read of the main CPU byte");
        finish_test("ram sharing", e0);
    endtask

    task automatic mailbox_handshake();
        int         e0;
        logic [7:0] hi, lo, ab, d;
        e0 = errors;
        hi = lcg_byte();
        lo = lcg_byte();
        ab = lcg_byte();
        cpu_write(16'hd000, hi);
        cpu_write(16'hd001, lo);
        cpu_write(16'hd002, ab);
        @(negedge clk48);
        check(32'(dsp_irq), 32'd1, "dsp_irq after the address byte");
        cpu_read(16'hd007, 1'b0, d);
        check(32'(d), 32'({1'b0, 3'b111, cur_bank}), "status while the DSP is busy");
        for (int i = 0; i < 2; i++) begin
            @(posedge clk48);
            #1;
            dsp_pids_n = 1'b0;
            @(negedge clk48);
            if (i == 0) check(32'(dsp_pbus_in), 32'({8'h00, ab}), "pbus_in on the first read");
            repeat (2) @(posedge clk48);
            #1;
            dsp_pids_n = 1'b1;
            repeat (2) @(posedge clk48);
            @(negedge clk48);
            check(32'(dsp_irq), 32'd0, "dsp_irq after a pids_n edge");
            check(32'(dsp_pbus_in), 32'({hi, lo}), "pbus_in data word");
        end
        cur_bank = 4'd3;
        cpu_write(16'hd003, 8'h83);
        @(negedge clk48);
        check(32'(dsp_rst), 32'd0, "dsp_rst after bank write 0x83");
        cpu_read(16'hd007, 1'b0, d);
        check(32'(d), 32'({1'b1, 3'b111, cur_bank}), "status after bank write");
        finish_test("mailbox", e0);
    endtask

    task automatic out_latch_capture();
        int          e0, s0;
        logic [15:0] a, b, exp_l, exp_r, lo;
        logic [ 6:0] hi;
        e0 = errors;
        a  = {lcg_byte(), lcg_byte()};
        b  = {lcg_byte(), lcg_byte()};
        lo = {lcg_byte(), lcg_byte()};
        hi = 7'(lcg_byte());
        exp_l = a << qsnd_pkg::AUDIO_SHIFT;
        exp_r = b << qsnd_pkg::AUDIO_SHIFT;
        @(posedge clk48);
        #1;
        dsp_psel = 1'b1;               // park psel high so the right word goes first
        repeat (3) @(posedge clk48);
        @(negedge clk48);
        s0 = sample_cnt;
        sadd_strobe(b, 1'b1);
        sadd_strobe(a, 1'b0);
        @(posedge clk48);
        #1;
        dsp_psel = 1'b1;               // publishes the pair
        repeat (4) @(posedge clk48);
        @(negedge clk48);
        check(32'($unsigned(left)), 32'(exp_l), "left sample");
        check(32'($unsigned(right)), 32'(exp_r), "right sample");
        check(32'(sample_cnt - s0), 32'd1, "sample pulses per pair");
        @(posedge clk48);
        #1;
        dsp_pbus_out = lo;
        dsp_pods_n   = 1'b0;
        repeat (2) @(posedge clk48);
        #1;
        dsp_pods_n = 1'b1;
        @(posedge clk48);
        #1;
        dsp_ab      = {1'b1, 8'd0, hi};
        dsp_cen_cko = 1'b1;
        @(posedge clk48);
        #1;
        dsp_cen_cko = 1'b0;
        dsp_ab      = 16'd0;
        @(negedge clk48);
        check(32'(qsnd_addr), 32'({hi, lo}), "qsnd_addr");
        finish_test("output latch", e0);
    endtask

    task automatic irq_timing();
        int   e0, n;
        logic in_window;
        e0 = errors;
        while (fall_tick < 0 && ticks <= qsnd_pkg::IRQ_PERIOD + 2) @(negedge clk48);
        if (fall_tick < 0) begin
            errors = errors + 1;
            $display("cpu_int_n never fell within %0d cen8 ticks", ticks);
        end else begin
            in_window = (fall_tick >= qsnd_pkg::IRQ_PERIOD) &&
                        (fall_tick <= qsnd_pkg::IRQ_PERIOD + 1);
            check(32'(in_window), 32'd1, "cpu_int_n fall tick in window");
        end
        @(posedge clk48);
        #1;
        cpu_addr   = 16'h0000;
        cpu_m1_n   = 1'b0;             // interrupt acknowledge cycle
        cpu_iorq_n = 1'b0;
        n = 0;
        while (!cpu_int_n && n < 16) begin
            @(negedge clk48);
            n = n + 1;
        end
        @(posedge clk48);
        #1;
        cpu_m1_n   = 1'b1;
        cpu_iorq_n = 1'b1;
        @(negedge clk48);
        check(32'(cpu_int_n), 32'd1, "cpu_int_n after acknowledge");
        finish_test("interrupt", e0);
    endtask

    initial begin
        rst          = 1'b1;
        cpu_addr     = 16'h0000;
        cpu_dout     = 8'h00;
        cpu_mreq_n   = 1'b1;
        cpu_rd_n     = 1'b1;
        cpu_wr_n     = 1'b1;
        cpu_m1_n     = 1'b1;
        cpu_iorq_n   = 1'b1;
        cpu_busak_n  = 1'b1;
        main_addr    = 23'd0;
        main_dout    = 8'h00;
        main_ldswn   = 1'b1;
        main_buse_n  = 1'b1;
        dsp_pids_n   = 1'b1;
        dsp_iack     = 1'b0;
        dsp_pods_n   = 1'b1;
        dsp_pbus_out = 16'd0;
        dsp_ab       = 16'd0;
        dsp_cen_cko  = 1'b0;
        dsp_sadd     = 1'b0;
        dsp_psel     = 1'b0;
        dsp_ser_out  = 16'd0;
        repeat (3) @(posedge clk48);
        #1;
        rst = 1'b0;
        reset_values();
        rom_bank_and_wait();
        ram_sharing();
        mailbox_handshake();
        out_latch_capture();
        irq_timing();
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
